//--- dv/cache_patterns.txt
// op_addr_wdata_expdata_exphit, op 0 read 1 write, all hex
// Four cache cells, reads return the last written word or zero
0_00_0000_0000_0
0_ff_0000_0000_0
1_10_1111_1111_0
0_10_0000_1111_1
1_20_2222_2222_0
1_30_3333_3333_0
1_40_4444_4444_0
1_50_5555_5555_0
0_10_0000_1111_0
0_30_0000_3333_1
0_60_0000_0000_0
0_70_0000_0000_0
0_80_0000_0000_0
0_30_0000_3333_1
0_40_0000_4444_0
1_80_8888_8888_1
0_80_0000_8888_1
1_80_8899_8899_1
0_80_0000_8899_1
0_70_0000_0000_1
1_ff_abcd_abcd_0
0_30_0000_3333_0
0_ff_0000_abcd_1
0_00_0000_0000_0
0_80_0000_8899_0
0_30_0000_3333_1

//--- build.f
rtl/cache_pkg.sv
rtl/lru_shift_store.sv
rtl/lru_cache.sv
rtl/backing_mem.sv
rtl/cache_ctrl.sv
rtl/cache_top.sv
dv/cache_sva.sv
dv/cache_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the cache testbench with Verilator, runs it and checks the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module cache_tb -f build.f -o cache_sim

./obj_dir/cache_sim | tee sim.log

if grep -qx "Test passed" sim.log; then
    exit 0
else
    exit 1
fi

//--- dv/cache_tb.sv
// Testbench for the LRU cache that replays access patterns from a file and checks each response
`timescale 1ns/1ps

module cache_tb import cache_pkg::*; ();

    localparam int CELL_CNT    = 4;
    localparam int MEM_LATENCY = 3;
    localparam int MAX_PAT     = 64;

    logic  clk;
    logic  rst;
    logic  req_valid;
    logic  req_we;
    addr_t req_addr;
    data_t req_wdata;
    logic  req_ready;
    logic  rsp_valid;
    data_t rsp_rdata;
    logic  rsp_hit;
    logic  rsp_ready;

    // One access per word as {op, addr, wdata, expected data, expected hit}
    // An op nibble of F marks a slot the file did not fill
    logic [47:0] pat_mem [MAX_PAT];

    int     n_pat;
    int     pass_cnt;
    int     fail_cnt;
    int     timeout_cycles;
    bit     loaded;
    integer seed;

    cache_top #(
        .CELL_CNT    (CELL_CNT),
        .MEM_LATENCY (MEM_LATENCY)
    ) cache_top_i (
        .clk       (clk),
        .rst       (rst),
        .req_valid (req_valid),
        .req_we    (req_we),
        .req_addr  (req_addr),
        .req_wdata (req_wdata),
        .req_ready (req_ready),
        .rsp_valid (rsp_valid),
        .rsp_rdata (rsp_rdata),
        .rsp_hit   (rsp_hit),
        .rsp_ready (rsp_ready)
    );

    // 100 ns clock period
    always #50 clk = ~clk;

    // Puts the request fields of one pattern on the bus and raises req_valid
    task automatic drive_request(input logic [47:0] pat);
        req_valid = 1'b1;
        req_we    = pat[44];
        req_addr  = pat[43:36];
        req_wdata = pat[35:20];
    endtask

    // Completes one access whose request is already on the bus and checks its response
    // The next request is offered while this response is held, so it has to wait its turn
    task automatic run_access(input int idx);
        logic [47:0] pat;
        logic        we;
        addr_t       addr;
        data_t       exp_data;
        logic        exp_hit;
        data_t       got_data;
        logic        got_hit;
        int          delay;
        bit          accepted;
        bit          blocked;
        bit          ok;
        pat      = pat_mem[idx];
        we       = pat[44];
        addr     = pat[43:36];
        exp_data = pat[19:4];
        exp_hit  = pat[0];
        ok       = 1'b1;
        blocked  = 1'b0;
        // A ready seen here means the transfer happens on the coming rising edge
        accepted = 1'b0;
        while (!accepted) begin
            accepted = req_ready;
            @(negedge clk);
        end
        req_valid = 1'b0;
        // Wait for the response, the watchdog bounds this loop
        while (!rsp_valid) begin
            @(negedge clk);
        end
        // The following access is already waiting while this response is pending
        if (idx + 1 < n_pat) begin
            drive_request(pat_mem[idx + 1]);
        end
        // Hold off the response for 0 to 3 cycles
        delay = {$random(seed)} % 4;
        repeat (delay) begin
            if (req_ready) begin
                blocked = 1'b1;
            end
            @(negedge clk);
        end
        if (req_ready) begin
            blocked = 1'b1;
        end
        if (blocked) begin
            $display("ERROR time %0t: req_ready went high while the response of access %0d was pending",
                     $time, idx);
            ok = 1'b0;
        end
        got_data = rsp_rdata;
        got_hit  = rsp_hit;
        if (got_data !== exp_data) begin
            $display("MISMATCH time %0t signal rsp_rdata expected %h actual %h",
                     $time, exp_data, got_data);
            ok = 1'b0;
        end
        if (got_hit !== exp_hit) begin
            $display("MISMATCH time %0t signal rsp_hit expected %b actual %b",
                     $time, exp_hit, got_hit);
            ok = 1'b0;
        end
        // Take the response on the next rising edge
        rsp_ready = 1'b1;
        @(negedge clk);
        rsp_ready = 1'b0;
        if (ok) begin
            pass_cnt++;
        end else begin
            fail_cnt++;
        end
        $display("access %0d %s addr %h rdata %h hit %b delay %0d: %s", idx,
                 we ? "write" : "read", addr, got_data, got_hit, delay, ok ? "ok" : "error");
    endtask

    initial begin
        clk       = 1'b0;
        rst       = 1'b1;
        req_valid = 1'b0;
        req_we    = 1'b0;
        req_addr  = '0;
        req_wdata = '0;
        rsp_ready = 1'b0;
        seed      = 32'h593d;
        n_pat     = 0;
        pass_cnt  = 0;
        fail_cnt  = 0;
        loaded    = 1'b0;
        // Fill with the end marker so the loaded length can be found
        for (int i = 0; i < MAX_PAT; i++) begin
            pat_mem[i] = '1;
        end
        $readmemh("dv/cache_patterns.txt", pat_mem);
        while (n_pat < MAX_PAT && pat_mem[n_pat][47:44] != 4'hF) begin
            n_pat++;
        end
        // Each access needs at most MEM_LATENCY + 8 cycles, plus room for reset
        timeout_cycles = n_pat * (MEM_LATENCY + 8) + 16;
        loaded = 1'b1;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        if (n_pat == 0) begin
            $display("No access patterns were loaded from dv/cache_patterns.txt");
            fail_cnt++;
        end else begin
            // The first request goes out one cycle after reset is released
            @(negedge clk);
            drive_request(pat_mem[0]);
        end
        for (int p = 0; p < n_pat; p++) begin
            run_access(p);
        end
        $display("Summary: %0d accesses, %0d passed, %0d failed", n_pat, pass_cnt, fail_cnt);
        if (fail_cnt == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    // Ends a run that stalls, such as a response that never arrives
    initial begin : watchdog
        wait (loaded);
        repeat (timeout_cycles) @(posedge clk);
        $display("Timeout after %0d clock cycles, the DUT stopped responding", timeout_cycles);
        $display("Test failed");
        $finish;
    end

endmodule

//--- dv/cache_sva.sv
// Handshake and reset-state assertions for the cache top level
`timescale 1ns/1ps

module cache_sva import cache_pkg::*; (
    input logic  clk,
    input logic  rst,
    input logic  req_valid,
    input logic  req_we,
    input addr_t req_addr,
    input data_t req_wdata,
    input logic  req_ready,
    input logic  rsp_valid,
    input data_t rsp_rdata,
    input logic  rsp_hit,
    input logic  rsp_ready
);

    // A waiting request keeps valid high and its fields unchanged
    a_req_hold: assert property (@(posedge clk) disable iff (rst)
        req_valid && !req_ready |=> req_valid && $stable(req_we) &&
            $stable(req_addr) && $stable(req_wdata))
        else $error("request withdrawn or changed before req_ready");

    // A pending response holds until the client takes it
    a_rsp_hold: assert property (@(posedge clk) disable iff (rst)
        rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp_rdata) && $stable(rsp_hit))
        else $error("response withdrawn or changed before rsp_ready");

    // No new request while a response is pending
    a_one_in_flight: assert property (@(posedge clk) disable iff (rst)
        !(rsp_valid && req_ready))
        else $error("req_ready high while a response is pending");

    // Reset leaves no response pending
    a_reset_rsp: assert property (@(posedge clk) rst |=> !rsp_valid)
        else $error("rsp_valid high right after reset");

endmodule

bind cache_top cache_sva sva_i (
    .clk       (clk),
    .rst       (rst),
    .req_valid (req_valid),
    .req_we    (req_we),
    .req_addr  (req_addr),
    .req_wdata (req_wdata),
    .req_ready (req_ready),
    .rsp_valid (rsp_valid),
    .rsp_rdata (rsp_rdata),
    .rsp_hit   (rsp_hit),
    .rsp_ready (rsp_ready)
);

//--- rtl/cache_top.sv
// LRU write-through cache in front of a slow backing memory
`timescale 1ns/1ps

module cache_top import cache_pkg::*; #(
    parameter int CELL_CNT    = 4,
    parameter int MEM_LATENCY = 3
) (
    input  logic  clk,
    input  logic  rst,
    input  logic  req_valid,
    input  logic  req_we,
    input  addr_t req_addr,
    input  data_t req_wdata,
    output logic  req_ready,
    output logic  rsp_valid,
    output data_t rsp_rdata,
    output logic  rsp_hit,
    input  logic  rsp_ready
);

    // Controller to cache
    addr_t lookup_addr;
    logic  upd;
    data_t upd_data;
    logic  hit;
    data_t hit_data;

    // Controller to backing memory
    logic  mem_req;
    logic  mem_we;
    addr_t mem_addr;
    data_t mem_wdata;
    logic  mem_done;
    data_t mem_rdata;

    cache_ctrl ctrl_i (
        .clk         (clk),
        .rst         (rst),
        .req_valid   (req_valid),
        .req_we      (req_we),
        .req_addr    (req_addr),
        .req_wdata   (req_wdata),
        .req_ready   (req_ready),
        .rsp_valid   (rsp_valid),
        .rsp_rdata   (rsp_rdata),
        .rsp_hit     (rsp_hit),
        .rsp_ready   (rsp_ready),
        .lookup_addr (lookup_addr),
        .upd         (upd),
        .upd_data    (upd_data),
        .hit         (hit),
        .hit_data    (hit_data),
        .mem_req     (mem_req),
        .mem_we      (mem_we),
        .mem_addr    (mem_addr),
        .mem_wdata   (mem_wdata),
        .mem_done    (mem_done),
        .mem_rdata   (mem_rdata)
    );

    lru_cache #(
        .CELL_CNT (CELL_CNT)
    ) cache_i (
        .clk         (clk),
        .rst         (rst),
        .lookup_addr (lookup_addr),
        .upd         (upd),
        .upd_data    (upd_data),
        .hit         (hit),
        .hit_data    (hit_data)
    );

    backing_mem #(
        .MEM_LATENCY (MEM_LATENCY)
    ) mem_i (
        .clk       (clk),
        .rst       (rst),
        .mem_req   (mem_req),
        .mem_we    (mem_we),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_done  (mem_done),
        .mem_rdata (mem_rdata)
    );

endmodule

//--- rtl/cache_ctrl.sv
// Request FSM for hits, fills, write-through and the response handshake
`timescale 1ns/1ps

module cache_ctrl import cache_pkg::*; (
    input  logic  clk,
    input  logic  rst,
    input  logic  req_valid,
    input  logic  req_we,
    input  addr_t req_addr,
    input  data_t req_wdata,
    output logic  req_ready,
    output logic  rsp_valid,
    output data_t rsp_rdata,
    output logic  rsp_hit,
    input  logic  rsp_ready,
    output addr_t lookup_addr,
    output logic  upd,
    output data_t upd_data,
    input  logic  hit,
    input  data_t hit_data,
    output logic  mem_req,
    output logic  mem_we,
    output addr_t mem_addr,
    output data_t mem_wdata,
    input  logic  mem_done,
    input  data_t mem_rdata
);

    ctrl_state_t state;
    ctrl_state_t state_next;

    // Captured request for the memory phase
    logic  we_q;
    addr_t addr_q;
    data_t wdata_q;
    // Hit flag seen when the request was accepted
    logic  hit_q;

    logic accept;
    logic fast_hit;

    // Only one request is ever in flight
    assign req_ready = (state == IDLE);
    assign rsp_valid = (state == RESP);
    assign accept    = req_valid && req_ready;

    // Only a read that hits completes without the backing memory
    assign fast_hit = accept && !req_we && hit;

    // While idle the cache looks at the incoming address directly
    assign lookup_addr = (state == IDLE) ? req_addr : addr_q;

    // Memory fields come straight from the request
    // The memory captures them on the mem_req edge
    assign mem_we    = req_we;
    assign mem_addr  = req_addr;
    assign mem_wdata = req_wdata;

    always_comb begin
        state_next = state;
        mem_req    = 1'b0;
        upd        = 1'b0;
        upd_data   = hit_data;
        case (state)
            IDLE: begin
                if (fast_hit) begin
                    // Refresh the hit entry to the youngest position
                    upd        = 1'b1;
                    state_next = RESP;
                end else if (accept) begin
                    // Read miss fetches, write goes through to memory
                    mem_req    = 1'b1;
                    state_next = MEM_WAIT;
                end
            end
            MEM_WAIT: begin
                // A write caches its own data and a read caches the fill word
                upd_data = we_q ? wdata_q : mem_rdata;
                if (mem_done) begin
                    upd        = 1'b1;
                    state_next = RESP;
                end
            end
            RESP: begin
                if (rsp_ready) begin
                    state_next = IDLE;
                end
            end
            default: begin
                state_next = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            state <= state_next;
        end
    end

    // Request capture and response payload
    always_ff @(posedge clk) begin
        if (accept) begin
            we_q    <= req_we;
            addr_q  <= req_addr;
            wdata_q <= req_wdata;
            hit_q   <= hit;
        end
        if (fast_hit) begin
            rsp_rdata <= hit_data;
            rsp_hit   <= 1'b1;
        end else if (state == MEM_WAIT && mem_done) begin
            // For a write the data echoes back with the hit seen on accept
            rsp_rdata <= upd_data;
            rsp_hit   <= hit_q;
        end
    end

endmodule

//--- rtl/backing_mem.sv
// Slow word memory over the full address space with a fixed access latency
`timescale 1ns/1ps

module backing_mem import cache_pkg::*; #(
    parameter int MEM_LATENCY = 3
) (
    input  logic  clk,
    input  logic  rst,
    input  logic  mem_req,
    input  logic  mem_we,
    input  addr_t mem_addr,
    input  data_t mem_wdata,
    output logic  mem_done,
    output data_t mem_rdata
);

    localparam int CNT_W = $clog2(MEM_LATENCY + 1);

    data_t            mem [2**ADDR_W];
    logic             busy;
    logic [CNT_W-1:0] cnt;
    logic             we_q;
    addr_t            addr_q;
    data_t            wdata_q;
    logic             fire;
    logic             acc_we;
    addr_t            acc_addr;
    data_t            acc_wdata;

    // Contents start at zero
    initial begin
        for (int i = 0; i < 2**ADDR_W; i++) begin
            mem[i] = '0;
        end
    end

    // The access happens on the last edge of the latency window
    // With a latency of one that is the request edge itself
    assign fire = (mem_req && MEM_LATENCY == 1) || (busy && cnt == CNT_W'(1));

    // Live request fields only matter when no request was captured
    assign acc_we    = busy ? we_q    : mem_we;
    assign acc_addr  = busy ? addr_q  : mem_addr;
    assign acc_wdata = busy ? wdata_q : mem_wdata;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy     <= 1'b0;
            cnt      <= '0;
            mem_done <= 1'b0;
        end else begin
            // Done is a single-cycle pulse right after the access edge
            mem_done <= fire;
            if (mem_req && !busy) begin
                busy <= (MEM_LATENCY > 1);
                cnt  <= CNT_W'(MEM_LATENCY - 1);
            end else if (busy) begin
                cnt <= cnt - CNT_W'(1);
                if (cnt == CNT_W'(1)) begin
                    busy <= 1'b0;
                end
            end
        end
    end

    // Request capture and the array itself
    always_ff @(posedge clk) begin
        if (mem_req && !busy) begin
            we_q    <= mem_we;
            addr_q  <= mem_addr;
            wdata_q <= mem_wdata;
        end
        if (fire) begin
            if (acc_we) begin
                mem[acc_addr] <= acc_wdata;
            end else begin
                mem_rdata <= mem[acc_addr];
            end
        end
    end

endmodule

//--- rtl/lru_cache.sv
// Fully associative lookup with LRU ordering kept by entry position
`timescale 1ns/1ps

module lru_cache import cache_pkg::*; #(
    parameter int CELL_CNT = 4
) (
    input  logic  clk,
    input  logic  rst,
    input  addr_t lookup_addr,
    input  logic  upd,
    input  data_t upd_data,
    output logic  hit,
    output data_t hit_data
);

    // Each entry is {valid, address, data} with the valid bit on top
    localparam int ENTRY_W = 1 + ADDR_W + DATA_W;

    logic [CELL_CNT*ENTRY_W-1:0] store_q;
    logic [ENTRY_W-1:0]          entry [CELL_CNT];
    logic [CELL_CNT-1:0]         match;
    logic [CELL_CNT-1:0]         age_mask;
    logic [CELL_CNT-1:0]         en;
    logic [ENTRY_W-1:0]          shift_in;

    // Unpack the store into one word per age position
    for (genvar g = 0; g < CELL_CNT; g++) begin : g_unpack
        assign entry[g] = store_q[g*ENTRY_W +: ENTRY_W];
    end

    // Compare the lookup address against every valid entry
    always_comb begin
        for (int i = 0; i < CELL_CNT; i++) begin
            match[i] = entry[i][ENTRY_W-1] &&
                       (entry[i][DATA_W +: ADDR_W] == lookup_addr);
        end
    end

    // An address is stored at most once, so at most one match bit is set
    assign hit = |match;

    always_comb begin
        hit_data = '0;
        for (int i = 0; i < CELL_CNT; i++) begin
            if (match[i]) begin
                hit_data = entry[i][DATA_W-1:0];
            end
        end
    end

    // Mark the hit position and every position younger than it
    // Sweeping from the oldest end, a bit stays set once the match is passed
    always_comb begin : p_age_mask
        logic seen;
        seen = 1'b0;
        for (int i = CELL_CNT - 1; i >= 0; i--) begin
            seen        = seen | match[i];
            age_mask[i] = seen;
        end
    end

    // A hit at position j shifts only 0..j, overwriting the old copy at j
    // A miss shifts everything and drops the oldest entry off the end
    always_comb begin
        if (!upd) begin
            en = '0;
        end else if (hit) begin
            en = age_mask;
        end else begin
            en = '1;
        end
    end

    // The accessed address always re-enters as the youngest valid entry
    assign shift_in = {1'b1, lookup_addr, upd_data};

    lru_shift_store #(
        .DEPTH (CELL_CNT),
        .WIDTH (ENTRY_W)
    ) store_i (
        .clk      (clk),
        .rst      (rst),
        .en       (en),
        .d        (shift_in),
        .q_packed (store_q)
    );

endmodule

//--- rtl/lru_shift_store.sv
// Word-wide shift register with a separate load enable for every position
`timescale 1ns/1ps

module lru_shift_store #(
    parameter int DEPTH = 4,
    parameter int WIDTH = 8
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic [DEPTH-1:0]       en,
    input  logic [WIDTH-1:0]       d,
    output logic [DEPTH*WIDTH-1:0] q_packed
);

    // Position 0 holds the youngest word and DEPTH-1 the oldest
    logic [WIDTH-1:0] q [DEPTH];

    // Next value each position would take when its enable is set
    logic [WIDTH-1:0] d_pos [DEPTH];

    always_comb begin
        // The new word enters at the front
        d_pos[0] = d;
        // Every other position takes the word one step younger than itself
        for (int i = 1; i < DEPTH; i++) begin
            d_pos[i] = q[i-1];
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            // An all-zero word is an invalid entry
            for (int i = 0; i < DEPTH; i++) begin
                q[i] <= '0;
            end
        end else begin
            for (int i = 0; i < DEPTH; i++) begin
                if (en[i]) begin
                    q[i] <= d_pos[i];
                end
            end
        end
    end

    // Flatten the positions so the parent can slice them by index
    for (genvar g = 0; g < DEPTH; g++) begin : g_pack
        assign q_packed[g*WIDTH +: WIDTH] = q[g];
    end

endmodule

//--- rtl/cache_pkg.sv
// Shared widths, vector types and controller states for the LRU cache
package cache_pkg;

    // Word address width, one address per data word
    localparam int ADDR_W = 8;

    // Data word width
    localparam int DATA_W = 16;

    // Word address as seen by the client, the cache and the backing memory
    typedef logic [ADDR_W-1:0] addr_t;

    // One data word
    typedef logic [DATA_W-1:0] data_t;

    // Request controller states
    // IDLE accepts a request, MEM_WAIT waits on the backing memory and RESP
    // holds the response until the client takes it
    typedef enum logic [1:0] {
        IDLE,
        MEM_WAIT,
        RESP
    } ctrl_state_t;

endpackage
